/* cpu6502_defs.svh */
`ifndef CPU6502_DEFS_SVH
`define CPU6502_DEFS_SVH

// bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// cycle count within one instruction
`define CPU_CYC_W 3

// first opcode fetch after reset
`define CPU_START_PC 16'h0200

// opcode split as aaabbbcc
`define OP_AAA_HI 7
`define OP_AAA_LO 5
`define OP_BBB_HI 4
`define OP_BBB_LO 2
`define OP_CC_HI 1
`define OP_CC_LO 0

`endif

/* cpu6502_pkg.sv */
`default_nettype none
`include "cpu6502_defs.svh"

package cpu6502_pkg;

   typedef logic [`CPU_DATA_W-1:0] byte_t;
   typedef logic [`CPU_ADDR_W-1:0] addr_t;
   typedef logic [`CPU_CYC_W-1:0]  cyc_t;

   typedef enum logic [3:0] {
      ALU_ADC,
      ALU_AND,
      ALU_ORA,
      ALU_EOR,
      ALU_PASS,
      ALU_INC,
      ALU_DEC,
      ALU_CLC,
      ALU_SEC
   } alu_op_e;

   // where the bus address comes from
   typedef enum logic [1:0] {ADDR_PC, ADDR_IDL_LOW, ADDR_IDL} addr_src_e;

   typedef enum logic [1:0] {DST_NONE, DST_A, DST_X} dst_e;

   typedef enum logic {OPSRC_A, OPSRC_X} opsrc_e;

   // supported opcodes, anything else runs as a two-cycle NOP
   typedef enum logic [7:0] {
      ORA_IMM = 8'h09, ORA_ZPG = 8'h05, ORA_ABS = 8'h0D,
      AND_IMM = 8'h29, AND_ZPG = 8'h25, AND_ABS = 8'h2D,
      EOR_IMM = 8'h49, EOR_ZPG = 8'h45, EOR_ABS = 8'h4D,
      ADC_IMM = 8'h69, ADC_ZPG = 8'h65, ADC_ABS = 8'h6D,
      STA_ZPG = 8'h85, STA_ABS = 8'h8D,
      LDA_IMM = 8'hA9, LDA_ZPG = 8'hA5, LDA_ABS = 8'hAD,
      LDX_IMM = 8'hA2,
      TAX     = 8'hAA,
      TXA     = 8'h8A,
      INX     = 8'hE8,
      DEX     = 8'hCA,
      CLC     = 8'h18,
      SEC     = 8'h38,
      JMP_ABS = 8'h4C,
      NOP     = 8'hEA
   } opcode_e;

endpackage

`default_nettype wire

/* ctrl_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface ctrl_if;
   import cpu6502_pkg::*;

   logic      pc_inc;
   logic      pc_load;
   logic      ir_load;
   logic      idl_low_load;
   logic      idl_hi_load;
   addr_src_e addr_src;
   logic      write;
   alu_op_e   alu_op;
   logic      op_b_mem;
   opsrc_e    opsrc;
   dst_e      dst;
   // final bus cycle of the instruction
   logic      last;

   modport rom (output pc_inc, pc_load, ir_load, idl_low_load, idl_hi_load, addr_src,
                write, alu_op, op_b_mem, opsrc, dst, last);

   modport seq (input ir_load, last);

   modport dp (input pc_inc, pc_load, idl_low_load, idl_hi_load, addr_src,
               write, alu_op, op_b_mem, opsrc, dst);

endinterface

`default_nettype wire

/* control_rom.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu6502_defs.svh"

module control_rom (
   ctrl_if.rom                ctrl,
   input  cpu6502_pkg::byte_t ir,
   input  cpu6502_pkg::byte_t fetch_data,
   input  cpu6502_pkg::cyc_t  cyc
);
   import cpu6502_pkg::*;

   byte_t      op;
   logic [2:0] aaa;
   logic [2:0] bbb;
   logic [1:0] cc;
   logic       arith_ok;
   alu_op_e    arith_op;

   // on the fetch cycle the opcode is still on the bus
   assign op  = (cyc == '0) ? fetch_data : ir;
   assign aaa = op[`OP_AAA_HI:`OP_AAA_LO];
   assign bbb = op[`OP_BBB_HI:`OP_BBB_LO];
   assign cc  = op[`OP_CC_HI:`OP_CC_LO];

   // kept cc=01 forms: ORA..LDA in zpg, imm, abs, no STA immediate
   assign arith_ok = (aaa <= 3'd5) && (bbb inside {3'b001, 3'b010, 3'b011}) &&
                     !(aaa == 3'd4 && bbb == 3'b010);

   always_comb begin
      case (aaa)
         3'd0:    arith_op = ALU_ORA;
         3'd1:    arith_op = ALU_AND;
         3'd2:    arith_op = ALU_EOR;
         3'd3:    arith_op = ALU_ADC;
         default: arith_op = ALU_PASS;
      endcase
   end

   always_comb begin
      // idle: read at PC, nothing written
      ctrl.pc_inc       = 1'b0;
      ctrl.pc_load      = 1'b0;
      ctrl.ir_load      = 1'b0;
      ctrl.idl_low_load = 1'b0;
      ctrl.idl_hi_load  = 1'b0;
      ctrl.addr_src     = ADDR_PC;
      ctrl.write        = 1'b0;
      ctrl.alu_op       = ALU_PASS;
      ctrl.op_b_mem     = 1'b0;
      ctrl.opsrc        = OPSRC_A;
      ctrl.dst          = DST_NONE;
      ctrl.last         = 1'b0;

      if (cyc == '0) begin
         ctrl.pc_inc  = 1'b1;
         ctrl.ir_load = 1'b1;
      end else if (cc == 2'b01 && arith_ok) begin
         if (cyc == 3'd1 && bbb == 3'b010) begin
            // immediate byte goes straight to the ALU
            ctrl.pc_inc   = 1'b1;
            ctrl.op_b_mem = 1'b1;
            ctrl.alu_op   = arith_op;
            ctrl.dst      = DST_A;
            ctrl.last     = 1'b1;
         end else if (cyc == 3'd1) begin
            ctrl.pc_inc       = 1'b1;
            ctrl.idl_low_load = 1'b1;
         end else if (cyc == 3'd2 && bbb == 3'b011) begin
            ctrl.pc_inc      = 1'b1;
            ctrl.idl_hi_load = 1'b1;
         end else begin
            // operand access, page zero or absolute
            ctrl.addr_src = (bbb == 3'b001) ? ADDR_IDL_LOW : ADDR_IDL;
            ctrl.last     = 1'b1;
            if (aaa == 3'd4) begin
               ctrl.write = 1'b1;
            end else begin
               ctrl.op_b_mem = 1'b1;
               ctrl.alu_op   = arith_op;
               ctrl.dst      = DST_A;
            end
         end
      end else begin
         // cc=10 and cc=00 groups: X, transfers, flags, jump
         ctrl.last = 1'b1;
         case (op)
            LDX_IMM: begin
               ctrl.pc_inc   = 1'b1;
               ctrl.op_b_mem = 1'b1;
               ctrl.dst      = DST_X;
            end
            TAX: ctrl.dst = DST_X;
            TXA: begin
               ctrl.opsrc = OPSRC_X;
               ctrl.dst   = DST_A;
            end
            INX, DEX: begin
               ctrl.alu_op = (op == INX) ? ALU_INC : ALU_DEC;
               ctrl.opsrc  = OPSRC_X;
               ctrl.dst    = DST_X;
            end
            CLC: ctrl.alu_op = ALU_CLC;
            SEC: ctrl.alu_op = ALU_SEC;
            JMP_ABS: begin
               if (cyc == 3'd1) begin
                  ctrl.pc_inc       = 1'b1;
                  ctrl.idl_low_load = 1'b1;
                  ctrl.last         = 1'b0;
               end else begin
                  // high byte comes off the bus this cycle
                  ctrl.pc_load = 1'b1;
               end
            end
            default: begin
               // NOP and unknown opcodes, dummy read of PC
               ctrl.last = 1'b1;
            end
         endcase
      end
   end

   // every instruction is done by its fourth bus cycle
   always_comb begin
      assert final (cyc != 3'd3 || ctrl.last)
         else $error("control ROM: no last cycle at cycle 3");
   end

endmodule

`default_nettype wire

/* cycle_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module cycle_sequencer (
   input  logic               clk,
   input  logic               reset,
   ctrl_if.seq                ctrl,
   input  logic               mem_ready,
   input  cpu6502_pkg::byte_t mem_rdata,
   output logic               mem_valid,
   output logic               sync,
   output logic               step,
   output cpu6502_pkg::byte_t ir,
   output cpu6502_pkg::cyc_t  cyc
);
   import cpu6502_pkg::*;

   logic valid_q;

   assign mem_valid = valid_q;
   assign step      = valid_q && mem_ready;
   assign sync      = valid_q && (cyc == '0);

   // bus goes live the cycle after reset drops
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
         cyc     <= '0;
      end else begin
         valid_q <= 1'b1;
         if (step) begin
            if (ctrl.last) begin
               cyc <= '0;
            end else begin
               cyc <= cyc + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (step && ctrl.ir_load) begin
         ir <= mem_rdata;
      end
   end

   // an accepted cycle 3 always wraps back to the fetch
   assert property (@(posedge clk) disable iff (reset) (step && cyc == 3'd3) |=> cyc == '0)
      else $error("cycle count passed 3");

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu6502_defs.svh"

module alu (
   input  cpu6502_pkg::alu_op_e op,
   input  cpu6502_pkg::byte_t   a,
   input  cpu6502_pkg::byte_t   b,
   input  logic                 carry_in,
   output cpu6502_pkg::byte_t   result,
   output logic                 n,
   output logic                 z,
   output logic                 c,
   output logic                 v,
   // which of {n, z, c, v} the op changes
   output logic [3:0]           flags_en
);
   import cpu6502_pkg::*;

   logic [`CPU_DATA_W:0] sum;

   assign sum = {1'b0, a} + {1'b0, b} + {{`CPU_DATA_W{1'b0}}, carry_in};

   always_comb begin
      result   = b;
      c        = carry_in;
      v        = 1'b0;
      flags_en = 4'b0000;
      case (op)
         ALU_ADC: begin
            result   = sum[`CPU_DATA_W-1:0];
            c        = sum[`CPU_DATA_W];
            // same-sign operands, different-sign result
            v        = (a[`CPU_DATA_W-1] == b[`CPU_DATA_W-1]) &&
                       (result[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
            flags_en = 4'b1111;
         end
         ALU_AND: begin
            result   = a & b;
            flags_en = 4'b1100;
         end
         ALU_ORA: begin
            result   = a | b;
            flags_en = 4'b1100;
         end
         ALU_EOR: begin
            result   = a ^ b;
            flags_en = 4'b1100;
         end
         ALU_PASS: flags_en = 4'b1100;
         ALU_INC: begin
            result   = a + 1'b1;
            flags_en = 4'b1100;
         end
         ALU_DEC: begin
            result   = a - 1'b1;
            flags_en = 4'b1100;
         end
         ALU_CLC: begin
            c        = 1'b0;
            flags_en = 4'b0010;
         end
         ALU_SEC: begin
            c        = 1'b1;
            flags_en = 4'b0010;
         end
         default: flags_en = 4'b0000;
      endcase
   end

   assign n = result[`CPU_DATA_W-1];
   assign z = (result == '0);

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu6502_defs.svh"

module reg_file (
   input  logic               clk,
   input  logic               reset,
   input  logic               step,
   ctrl_if.dp                 ctrl,
   input  cpu6502_pkg::byte_t mem_rdata,
   input  cpu6502_pkg::byte_t alu_result,
   input  logic               alu_n,
   input  logic               alu_z,
   input  logic               alu_c,
   input  logic               alu_v,
   input  logic [3:0]         alu_flags_en,
   output cpu6502_pkg::byte_t alu_a,
   output cpu6502_pkg::byte_t alu_b,
   output logic               carry,
   output cpu6502_pkg::addr_t mem_addr,
   output logic               mem_write,
   output cpu6502_pkg::byte_t mem_wdata
);
   import cpu6502_pkg::*;

   addr_t      pc;
   byte_t      idl_low;
   byte_t      idl_hi;
   byte_t      a_reg;
   byte_t      x_reg;
   // n, z, c, v
   logic [3:0] flags;
   logic       alu_live;

   assign alu_a = (ctrl.opsrc == OPSRC_X) ? x_reg : a_reg;
   // register moves pass the selected register through b
   assign alu_b = ctrl.op_b_mem ? mem_rdata : alu_a;
   assign carry = flags[1];

   assign alu_live = (ctrl.dst != DST_NONE) || (ctrl.alu_op == ALU_CLC) ||
                     (ctrl.alu_op == ALU_SEC);

   always_comb begin
      case (ctrl.addr_src)
         ADDR_IDL_LOW: mem_addr = {8'h00, idl_low};
         ADDR_IDL:     mem_addr = {idl_hi, idl_low};
         default:      mem_addr = pc;
      endcase
   end

   assign mem_write = ctrl.write;
   assign mem_wdata = a_reg;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc    <= `CPU_START_PC;
         a_reg <= '0;
         x_reg <= '0;
         flags <= '0;
      end else if (step) begin
         if (ctrl.pc_load) begin
            pc <= {mem_rdata, idl_low};
         end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1;
         end
         if (ctrl.dst == DST_A) begin
            a_reg <= alu_result;
         end
         if (ctrl.dst == DST_X) begin
            x_reg <= alu_result;
         end
         if (alu_live) begin
            flags <= (flags & ~alu_flags_en) |
                     ({alu_n, alu_z, alu_c, alu_v} & alu_flags_en);
         end
      end
   end

   // operand address latches
   always_ff @(posedge clk) begin
      if (step && ctrl.idl_low_load) begin
         idl_low <= mem_rdata;
      end
      if (step && ctrl.idl_hi_load) begin
         idl_hi <= mem_rdata;
      end
   end

   // a stalled store keeps its address and data on the bus
   assert property (@(posedge clk) disable iff (reset)
                    (mem_write && !step) |=> mem_write && $stable(mem_addr) &&
                                             $stable(mem_wdata))
      else $error("store changed on the bus while stalled");

endmodule

`default_nettype wire

/* cpu6502_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu6502_top (
   input  logic               clk,
   input  logic               reset,
   output logic               mem_valid,
   output logic               mem_write,
   output cpu6502_pkg::addr_t mem_addr,
   output cpu6502_pkg::byte_t mem_wdata,
   input  logic               mem_ready,
   input  cpu6502_pkg::byte_t mem_rdata,
   output logic               sync
);
   import cpu6502_pkg::*;

   logic       step;
   byte_t      ir;
   cyc_t       cyc;
   byte_t      alu_a;
   byte_t      alu_b;
   byte_t      alu_result;
   logic       alu_n;
   logic       alu_z;
   logic       alu_c;
   logic       alu_v;
   logic [3:0] alu_flags_en;
   logic       carry;

   ctrl_if ctrl ();

   control_rom control_rom_i (
      .ctrl       (ctrl.rom),
      .ir         (ir),
      .fetch_data (mem_rdata),
      .cyc        (cyc)
   );

   cycle_sequencer cycle_sequencer_i (
      .clk       (clk),
      .reset     (reset),
      .ctrl      (ctrl.seq),
      .mem_ready (mem_ready),
      .mem_rdata (mem_rdata),
      .mem_valid (mem_valid),
      .sync      (sync),
      .step      (step),
      .ir        (ir),
      .cyc       (cyc)
   );

   alu alu_i (
      .op       (ctrl.alu_op),
      .a        (alu_a),
      .b        (alu_b),
      .carry_in (carry),
      .result   (alu_result),
      .n        (alu_n),
      .z        (alu_z),
      .c        (alu_c),
      .v        (alu_v),
      .flags_en (alu_flags_en)
   );

   reg_file reg_file_i (
      .clk          (clk),
      .reset        (reset),
      .step         (step),
      .ctrl         (ctrl.dp),
      .mem_rdata    (mem_rdata),
      .alu_result   (alu_result),
      .alu_n        (alu_n),
      .alu_z        (alu_z),
      .alu_c        (alu_c),
      .alu_v        (alu_v),
      .alu_flags_en (alu_flags_en),
      .alu_a        (alu_a),
      .alu_b        (alu_b),
      .carry        (carry),
      .mem_addr     (mem_addr),
      .mem_write    (mem_write),
      .mem_wdata    (mem_wdata)
   );

endmodule

`default_nettype wire

/* tb_cpu6502.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu6502_defs.svh"

module tb_cpu6502;
   import cpu6502_pkg::*;

   localparam int CLK_PERIOD = 100;

   typedef struct packed {
      addr_t next_pc;
      logic  store;
      addr_t st_addr;
      byte_t st_data;
      cyc_t  cycles;
   } instr_result_t;

   logic  clk = 1'b0;
   logic  reset;
   logic  mem_valid;
   logic  mem_write;
   addr_t mem_addr;
   byte_t mem_wdata;
   logic  mem_ready;
   byte_t mem_rdata;
   logic  sync;

   byte_t mem [0:65535];
   byte_t ref_mem [0:65535];

   // reference machine state, reset values of the core
   addr_t ref_pc = `CPU_START_PC;
   byte_t ref_a = 8'h00;
   byte_t ref_x = 8'h00;
   logic  ref_c = 1'b0;

   addr_t prog_ptr;
   addr_t end_pc;
   byte_t st_zp;
   int    n_instr = 0;
   logic  prog_ready = 1'b0;
   logic  done = 1'b0;
   logic  started = 1'b0;
   cyc_t  cycles_seen = '0;
   cyc_t  exp_cycles = '0;
   addr_t wr_addr_q [$];
   byte_t wr_data_q [$];

   cpu6502_top cpu6502_top_i (
      .clk       (clk),
      .reset     (reset),
      .mem_valid (mem_valid),
      .mem_write (mem_write),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ready (mem_ready),
      .mem_rdata (mem_rdata),
      .sync      (sync)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string why);
      $display("ERROR: %s", why);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_fetch(input addr_t expected, input addr_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: mem_addr on fetch expected %h, actual %h",
                  $time, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "fetch address mismatch");
      end
   endtask

   task automatic check_write(input addr_t exp_addr, input byte_t exp_data,
                              input addr_t act_addr, input byte_t act_data);
      if (act_addr !== exp_addr || act_data !== exp_data) begin
         $display("CHECK FAILED at %0t: mem_addr expected %h, actual %h",
                  $time, exp_addr, act_addr);
         $display("CHECK FAILED at %0t: mem_wdata expected %h, actual %h",
                  $time, exp_data, act_data);
         $display("RESULT: FAIL");
         $fatal(1, "store mismatch");
      end
   endtask

   task automatic check_cycles(input cyc_t expected, input cyc_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: bus cycles per instruction expected %0d, actual %0d",
                  $time, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "instruction length mismatch");
      end
   endtask

   // program assembly into the memory model
   task automatic emit_byte(input byte_t value);
      mem[prog_ptr] = value;
      prog_ptr      = prog_ptr + 16'd1;
   endtask

   task automatic one_byte_op(input byte_t op);
      emit_byte(op);
      n_instr++;
   endtask

   task automatic two_byte_op(input byte_t op, input byte_t arg);
      emit_byte(op);
      emit_byte(arg);
      n_instr++;
   endtask

   task automatic three_byte_op(input byte_t op, input addr_t target);
      emit_byte(op);
      emit_byte(target[7:0]);
      emit_byte(target[15:8]);
      n_instr++;
   endtask

   // store A in the next free page-zero slot
   task automatic store_next();
      two_byte_op(STA_ZPG, st_zp);
      st_zp = st_zp + 8'd1;
   endtask

   task automatic write_program();
      prog_ptr = `CPU_START_PC;
      st_zp    = 8'h80;
      two_byte_op(LDA_IMM, 8'h5A);
      store_next();
      two_byte_op(LDA_ZPG, 8'h10);
      three_byte_op(STA_ABS, 16'h1100);
      three_byte_op(LDA_ABS, 16'h1000);
      store_next();
      // adc after clc and sec
      // carry set first so that clc has something to clear
      one_byte_op(SEC);
      one_byte_op(CLC);
      two_byte_op(ADC_IMM, 8'h37);
      store_next();
      one_byte_op(SEC);
      two_byte_op(ADC_ZPG, 8'h11);
      store_next();
      one_byte_op(CLC);
      three_byte_op(ADC_ABS, 16'h1001);
      three_byte_op(STA_ABS, 16'h1101);
      one_byte_op(SEC);
      two_byte_op(ADC_IMM, 8'hFF);
      store_next();
      // carry out of the add above feeds this one
      two_byte_op(ADC_IMM, 8'h80);
      store_next();
      two_byte_op(LDA_ZPG, 8'h20);
      two_byte_op(AND_IMM, 8'hF7);
      store_next();
      two_byte_op(AND_ZPG, 8'h21);
      store_next();
      three_byte_op(AND_ABS, 16'h1002);
      store_next();
      two_byte_op(ORA_IMM, 8'h0F);
      store_next();
      two_byte_op(ORA_ZPG, 8'h22);
      store_next();
      three_byte_op(ORA_ABS, 16'h1003);
      store_next();
      two_byte_op(EOR_IMM, 8'hAA);
      store_next();
      two_byte_op(EOR_ZPG, 8'h23);
      store_next();
      three_byte_op(EOR_ABS, 16'h1004);
      store_next();
      // x register, wrap in both directions
      two_byte_op(LDX_IMM, 8'hFE);
      one_byte_op(INX);
      one_byte_op(TXA);
      store_next();
      one_byte_op(INX);
      one_byte_op(TXA);
      store_next();
      one_byte_op(DEX);
      one_byte_op(TXA);
      store_next();
      two_byte_op(LDA_IMM, 8'h7F);
      one_byte_op(TAX);
      one_byte_op(INX);
      one_byte_op(TXA);
      store_next();
      // nop and two opcodes outside the kept set
      one_byte_op(NOP);
      one_byte_op(8'h02);
      one_byte_op(8'h89);
      store_next();
      three_byte_op(JMP_ABS, 16'h0340);
      prog_ptr = 16'h0340;
      two_byte_op(LDA_ZPG, 8'h80);
      three_byte_op(EOR_ABS, 16'h1100);
      three_byte_op(STA_ABS, 16'h1102);
      // jump to itself marks the end
      end_pc = prog_ptr;
      three_byte_op(JMP_ABS, end_pc);
   endtask

   task automatic load_memory();
      for (int i = 0; i < 65536; i++) begin
         mem[i] = i[15:8] ^ i[7:0] ^ 8'h3C;
      end
      for (int i = 0; i < 256; i++) begin
         mem[i]            = byte_t'($urandom());
         mem[16'h1000 + i] = byte_t'($urandom());
      end
      write_program();
      for (int i = 0; i < 65536; i++) begin
         ref_mem[i] = mem[i];
      end
   endtask

   // one instruction of the reference machine
   function automatic instr_result_t run_reference();
      instr_result_t r;
      byte_t         op;
      byte_t         lo;
      byte_t         hi;
      byte_t         operand;
      addr_t         ea;
      logic [8:0]    sum;
      op        = ref_mem[ref_pc];
      lo        = ref_mem[ref_pc + 16'd1];
      hi        = ref_mem[ref_pc + 16'd2];
      r         = '0;
      r.next_pc = ref_pc + 16'd1;
      r.cycles  = 3'd2;
      ea        = '0;
      // length and effective address by mode
      case (op)
         LDA_IMM, ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM, LDX_IMM: begin
            r.next_pc = ref_pc + 16'd2;
         end
         LDA_ZPG, ADC_ZPG, AND_ZPG, ORA_ZPG, EOR_ZPG, STA_ZPG: begin
            ea        = {8'h00, lo};
            r.next_pc = ref_pc + 16'd2;
            r.cycles  = 3'd3;
         end
         LDA_ABS, ADC_ABS, AND_ABS, ORA_ABS, EOR_ABS, STA_ABS: begin
            ea        = {hi, lo};
            r.next_pc = ref_pc + 16'd3;
            r.cycles  = 3'd4;
         end
         JMP_ABS: begin
            r.next_pc = {hi, lo};
            r.cycles  = 3'd3;
         end
         default: ;
      endcase
      operand = (r.cycles == 3'd2) ? lo : ref_mem[ea];
      case (op)
         LDA_IMM, LDA_ZPG, LDA_ABS: ref_a = operand;
         AND_IMM, AND_ZPG, AND_ABS: ref_a = ref_a & operand;
         ORA_IMM, ORA_ZPG, ORA_ABS: ref_a = ref_a | operand;
         EOR_IMM, EOR_ZPG, EOR_ABS: ref_a = ref_a ^ operand;
         ADC_IMM, ADC_ZPG, ADC_ABS: begin
            sum   = {1'b0, ref_a} + {1'b0, operand} + {8'h00, ref_c};
            ref_a = sum[7:0];
            ref_c = sum[8];
         end
         STA_ZPG, STA_ABS: begin
            r.store     = 1'b1;
            r.st_addr   = ea;
            r.st_data   = ref_a;
            ref_mem[ea] = ref_a;
         end
         LDX_IMM: ref_x = operand;
         TAX:     ref_x = ref_a;
         TXA:     ref_a = ref_x;
         INX:     ref_x = ref_x + 8'd1;
         DEX:     ref_x = ref_x - 8'd1;
         CLC:     ref_c = 1'b0;
         SEC:     ref_c = 1'b1;
         default: ;
      endcase
      return r;
   endfunction

   // memory model, read data and ready change on the falling edge
   always @(negedge clk) begin
      mem_ready <= ($urandom() % 100) < 70;
      mem_rdata <= mem[mem_addr];
   end

   always @(posedge clk) begin
      if (!reset && mem_valid && mem_ready && mem_write) begin
         mem[mem_addr] <= mem_wdata;
      end
   end

   always @(posedge clk) begin : compare_bus
      instr_result_t res;
      // once the bus is live it stays requesting
      if (started && mem_valid !== 1'b1) begin
         abort_run("mem_valid went low after the bus had started");
      end
      if (!reset && !done && mem_valid && mem_ready) begin
         if (sync) begin
            if (started) begin
               check_cycles(exp_cycles, cycles_seen);
            end
            if (wr_addr_q.size() != 0) begin
               abort_run("a store expected by the reference never reached the bus");
            end
            check_fetch(ref_pc, mem_addr);
            started     = 1'b1;
            cycles_seen = 3'd1;
            if (ref_pc == end_pc) begin
               done = 1'b1;
            end else begin
               res        = run_reference();
               ref_pc     = res.next_pc;
               exp_cycles = res.cycles;
               if (res.store) begin
                  wr_addr_q.push_back(res.st_addr);
                  wr_data_q.push_back(res.st_data);
               end
            end
         end else if (cycles_seen != 3'd7) begin
            cycles_seen = cycles_seen + 3'd1;
         end
         if (mem_write) begin
            if (wr_addr_q.size() == 0) begin
               abort_run("mem_write was asserted where no store was expected");
            end else begin
               check_write(wr_addr_q.pop_front(), wr_data_q.pop_front(),
                           mem_addr, mem_wdata);
            end
         end
      end
   end

   initial begin : watchdog
      wait (prog_ready);
      #((16 + n_instr * 40 * 2) * CLK_PERIOD);
      abort_run("timeout, the program did not complete in the allowed time");
   end

   initial begin
      reset     = 1'b1;
      mem_ready = 1'b0;
      mem_rdata = '0;
      void'($urandom(32'hb812));
      load_memory();
      prog_ready = 1'b1;
      // bus stays idle while reset is held
      repeat (16) begin
         @(negedge clk);
         if (mem_valid !== 1'b0 || mem_write !== 1'b0) begin
            abort_run("bus was active during reset");
         end
      end
      reset <= 1'b0;
      wait (done);
      @(negedge clk);
      if (wr_addr_q.size() == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         abort_run("stores were still outstanding at the end of the program");
      end
   end

endmodule

`default_nettype wire

/* cpu6502_top.f */
+incdir+.
cpu6502_pkg.sv
ctrl_if.sv
control_rom.sv
cycle_sequencer.sv
alu.sv
reg_file.sv
cpu6502_top.sv
tb_cpu6502.sv

/* Bender.yml */
package:
  name: cpu6502

export_include_dirs:
  - .

sources:
  - cpu6502_pkg.sv
  - ctrl_if.sv
  - control_rom.sv
  - cycle_sequencer.sv
  - alu.sv
  - reg_file.sv
  - cpu6502_top.sv
  - target: simulation
    files:
      - tb_cpu6502.sv
